//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := mul_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mul_clk_gen.sv
`default_nettype none

// free running clock for the testbench
module mul_clk_gen (
  output logic o_clk
);

  localparam int HALF_PERIOD = 2;  // period of 4

  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_PERIOD o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

//--- dv/mul_tb.sv
`default_nettype none

module mul_tb import mul_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 16;
  localparam int IDLE_CYCLES = 20;
  localparam int N_CORNER    = 5;
  localparam int N_RAND      = 200;
  localparam int N_B2B       = 300;
  localparam int N_FLUSH     = 300;

  // a random gap after an issue can double the cycles of tests 2 and 3
  localparam int TEST_CYCLES = RST_CYCLES + IDLE_CYCLES + 2
                             + 2 * (2 * N_CORNER * N_CORNER + N_RAND)
                             + 2 * (3 * N_CORNER * N_CORNER + N_RAND)
                             + N_B2B + N_FLUSH + 4;
  localparam int MARGIN         = 200;
  localparam int WATCHDOG_LIMIT = (TEST_CYCLES + MARGIN) * CLK_PERIOD;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    mul_op_e          op;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic             flushed;
    logic [31:0]      cyc;     // cycle the op was driven in
  } exp_entry_t;

  logic             clk;
  logic             i_rst_n;
  logic             i_valid;
  logic             i_flush;
  mul_op_e          i_op;
  logic [TAG_W-1:0] i_tag;
  logic [XLEN-1:0]  i_multiplicand;
  logic [XLEN-1:0]  i_multiplier;
  logic             o_out_valid;
  logic [TAG_W-1:0] o_out_tag;
  logic [XLEN-1:0]  o_result;

  exp_entry_t       exp_q[$];
  logic [31:0]      rng_state  = 32'h53cd;
  logic [31:0]      cycle_cnt  = '0;
  logic [TAG_W-1:0] tag_ctr    = '0;
  logic             checking   = 1'b0;
  int               mon_checks = 0;
  int               mon_errors = 0;
  int               seq_checks = 0;
  int               seq_errors = 0;

  exp_entry_t       mon_ent;
  logic             mon_have;
  logic [XLEN-1:0]  mon_exp;

  mul_clk_gen u_clk (
    .o_clk (clk)
  );

  mul_unit_top dut0 (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .i_flush        (i_flush),
    .i_op           (i_op),
    .i_tag          (i_tag),
    .i_multiplicand (i_multiplicand),
    .i_multiplier   (i_multiplier),
    .o_out_valid    (o_out_valid),
    .o_out_tag      (o_out_tag),
    .o_result       (o_result)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {rand32(), rand32()};
  endfunction

  function automatic logic [XLEN-1:0] corner_val(input int idx);
    case (idx)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, {(XLEN-1){1'b0}}};  // most negative
      3:       return {1'b0, {(XLEN-1){1'b1}}};
      default: return {{(XLEN-1){1'b0}}, 1'b1};
    endcase
  endfunction

  function automatic mul_op_e high_op(input int k);
    case (k)
      0:       return MUL_OP_MULH;
      1:       return MUL_OP_MULHSU;
      default: return MUL_OP_MULHU;
    endcase
  endfunction

  // full 128-bit product with operand extension per opcode
  function automatic logic [XLEN-1:0] model_result(input mul_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    logic              a_signed;
    logic              b_signed;
    a_signed = (op == MUL_OP_MULH) || (op == MUL_OP_MULHSU);
    b_signed = (op == MUL_OP_MULH);
    ea = a_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    eb = b_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    prod = ea * eb;
    case (op)
      MUL_OP_MULH, MUL_OP_MULHSU, MUL_OP_MULHU: return prod[2*XLEN-1:XLEN];
      MUL_OP_MULW: return {{(XLEN/2){prod[XLEN/2-1]}}, prod[XLEN/2-1:0]};
      default:     return prod[XLEN-1:0];
    endcase
  endfunction

  function automatic int total_errors();
    return mon_errors + seq_errors;
  endfunction

  task automatic issue_op(input mul_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic flush);
    exp_entry_t ent;
    i_valid        = 1'b1;
    i_flush        = flush;
    i_op           = op;
    i_tag          = tag_ctr;
    i_multiplicand = a;
    i_multiplier   = b;
    ent.tag     = tag_ctr;
    ent.op      = op;
    ent.a       = a;
    ent.b       = b;
    ent.flushed = flush;
    ent.cyc     = cycle_cnt;
    exp_q.push_back(ent);
    tag_ctr = tag_ctr + 1'b1;
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    i_flush = 1'b0;
  endtask

  task automatic idle_cycle(input logic flush);
    i_valid = 1'b0;
    i_flush = flush;  // flush with nothing issued
    @(posedge clk);
    #1;
    i_flush = 1'b0;
  endtask

  task automatic random_gap();
    logic [31:0] r;
    r = rand32();
    if (r[0]) begin
      idle_cycle(1'b0);
    end
  endtask

  // latency is one cycle, the last result is checked within this one
  task automatic drain();
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int ops, input int err_start);
    $display("test %s finished: %0d ops, %0d errors", name, ops, total_errors() - err_start);
  endtask

  // output monitor, mid cycle where outputs are stable
  always @(negedge clk) begin
    if (checking) begin
      mon_have = 1'b0;
      if (exp_q.size() > 0 && exp_q[0].cyc + 1 == cycle_cnt) begin
        mon_ent  = exp_q.pop_front();
        mon_have = 1'b1;
      end
      if (mon_have && !mon_ent.flushed) begin
        mon_checks++;
        if (!o_out_valid) begin
          $display("no output one cycle after issue of tag %0d at t=%0t", mon_ent.tag, $time);
          mon_errors++;
        end else begin
          mon_exp = model_result(mon_ent.op, mon_ent.a, mon_ent.b);
          if (o_out_tag !== mon_ent.tag) begin
            $display("CHECK FAILED t=%0t o_out_tag expected %0d got %0d",
                     $time, mon_ent.tag, o_out_tag);
            mon_errors++;
          end
          mon_checks++;
          if (o_result !== mon_exp) begin
            $display("CHECK FAILED t=%0t o_result expected %h got %h",
                     $time, mon_exp, o_result);
            mon_errors++;
          end
        end
      end else begin
        mon_checks++;
        if (o_out_valid) begin
          if (mon_have) begin
            $display("flushed operation with tag %0d produced an output at t=%0t",
                     mon_ent.tag, $time);
          end else begin
            $display("output with tag %0d at t=%0t and no pending operation",
                     o_out_tag, $time);
          end
          mon_errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_LIMIT);
    $display("watchdog expired after %0d time units, run did not complete", WATCHDOG_LIMIT);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int          err_start;
    int          ops;
    logic [31:0] r;
    mul_op_e     op;

    i_rst_n        = 1'b0;
    i_valid        = 1'b0;
    i_flush        = 1'b0;
    i_op           = MUL_OP_MUL;
    i_tag          = '0;
    i_multiplicand = '0;
    i_multiplier   = '0;

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    i_rst_n  = 1'b1;
    checking = 1'b1;

    // test 1, idle after reset
    err_start = total_errors();
    @(negedge clk);
    seq_checks++;
    if (o_out_tag !== '0) begin
      $display("CHECK FAILED t=%0t o_out_tag expected 0 got %0d", $time, o_out_tag);
      seq_errors++;
    end
    seq_checks++;
    if (o_result !== '0) begin
      $display("CHECK FAILED t=%0t o_result expected 0 got %h", $time, o_result);
      seq_errors++;
    end
    @(posedge clk);
    #1;
    repeat (IDLE_CYCLES) idle_cycle(1'b0);
    report_test("reset_idle", 0, err_start);

    // test 2, low result and word result
    err_start = total_errors();
    ops = 0;
    for (int i = 0; i < N_CORNER; i++) begin
      for (int j = 0; j < N_CORNER; j++) begin
        for (int k = 0; k < 2; k++) begin
          op = (k == 0) ? MUL_OP_MUL : MUL_OP_MULW;
          issue_op(op, corner_val(i), corner_val(j), 1'b0);
          random_gap();
          ops++;
        end
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      r = rand32();
      op = r[0] ? MUL_OP_MULW : MUL_OP_MUL;
      issue_op(op, rand64(), rand64(), 1'b0);
      random_gap();
      ops++;
    end
    drain();
    report_test("mul_mulw", ops, err_start);

    // test 3, high half for each signedness
    err_start = total_errors();
    ops = 0;
    for (int i = 0; i < N_CORNER; i++) begin
      for (int j = 0; j < N_CORNER; j++) begin
        for (int k = 0; k < 3; k++) begin
          issue_op(high_op(k), corner_val(i), corner_val(j), 1'b0);
          random_gap();
          ops++;
        end
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      r = rand32();
      issue_op(high_op(int'(r % 3)), rand64(), rand64(), 1'b0);
      random_gap();
      ops++;
    end
    drain();
    report_test("mulh_family", ops, err_start);

    // test 4, one op every cycle
    err_start = total_errors();
    ops = 0;
    for (int n = 0; n < N_B2B; n++) begin
      r = rand32();
      issue_op(mul_op_e'(3'(r % 5)), rand64(), rand64(), 1'b0);
      ops++;
    end
    drain();
    report_test("back_to_back", ops, err_start);

    // test 5, random flushes in issue cycles
    err_start = total_errors();
    ops = 0;
    for (int n = 0; n < N_FLUSH; n++) begin
      r = rand32();
      if (r[7:5] == 3'd0) begin
        idle_cycle(1'b1);
      end else begin
        issue_op(mul_op_e'(3'(r[31:8] % 5)), rand64(), rand64(), r[1:0] == 2'd0);
        ops++;
      end
    end
    drain();
    report_test("flush", ops, err_start);

    $display("checks passed %0d, failed %0d",
             mon_checks + seq_checks - total_errors(), total_errors());
    if (total_errors() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/mul_pkg.sv
source/mul_stage_if.sv
source/mul_op_decode.sv
source/mul_partial_stage.sv
source/mul_sum_stage.sv
source/mul_unit_top.sv
dv/mul_clk_gen.sv
dv/mul_tb.sv

//--- source/mul_op_decode.sv
`default_nettype none

module mul_op_decode import mul_pkg::*; (
  input  mul_op_e   i_op,
  output mul_ctrl_t o_ctrl
);

  always_comb begin
    o_ctrl = '0;
    case (i_op)
      MUL_OP_MULH: begin
        o_ctrl.src1_signed = 1'b1;
        o_ctrl.src2_signed = 1'b1;
        o_ctrl.sel_hi      = 1'b1;
      end

      MUL_OP_MULHSU: begin
        o_ctrl.src1_signed = 1'b1;  // multiplier stays unsigned
        o_ctrl.src2_signed = 1'b0;
        o_ctrl.sel_hi      = 1'b1;
      end

      MUL_OP_MULHU: begin
        o_ctrl.src1_signed = 1'b0;
        o_ctrl.src2_signed = 1'b0;
        o_ctrl.sel_hi      = 1'b1;
      end

      // low 32 bits of the full product are already right,
      // only the sign extension differs from MUL
      MUL_OP_MULW: begin
        o_ctrl.src1_signed = 1'b0;
        o_ctrl.src2_signed = 1'b0;
        o_ctrl.word        = 1'b1;
      end

      MUL_OP_MUL: begin
        o_ctrl.src1_signed = 1'b0;  // low half is sign agnostic
        o_ctrl.src2_signed = 1'b0;
        o_ctrl.sel_hi      = 1'b0;
      end

      default: begin
        // unknown encodings behave as MUL
        o_ctrl.sel_hi      = 1'b0;
        o_ctrl.word        = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/mul_partial_stage.sv
`default_nettype none

module mul_partial_stage import mul_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,

  input  logic              i_valid,
  input  logic              i_flush,
  input  logic [TAG_W-1:0]  i_tag,
  input  mul_ctrl_t         i_ctrl,
  input  logic [XLEN-1:0]   i_multiplicand,
  input  logic [XLEN-1:0]   i_multiplier,

  mul_stage_if.producer     o_stg
);

  localparam int LO_W = XLEN / 2;

  // operand halves, each with an explicit sign bit on top
  logic signed [HALF_W-1:0] lo_src1;
  logic signed [HALF_W-1:0] hi_src1;
  logic signed [HALF_W-1:0] lo_src2;
  logic signed [HALF_W-1:0] hi_src2;

  logic signed [PP_W-1:0]   pp_ll;
  logic signed [PP_W-1:0]   pp_lh;
  logic signed [PP_W-1:0]   pp_hl;
  logic signed [PP_W-1:0]   pp_hh;

  logic                     accept;

  // low halves are always positive
  assign lo_src1 = {1'b0, i_multiplicand[LO_W-1:0]};
  assign lo_src2 = {1'b0, i_multiplier[LO_W-1:0]};

  assign hi_src1 = {i_ctrl.src1_signed & i_multiplicand[XLEN-1],
                    i_multiplicand[XLEN-1:LO_W]};
  assign hi_src2 = {i_ctrl.src2_signed & i_multiplier[XLEN-1],
                    i_multiplier[XLEN-1:LO_W]};

  // 33x33 signed products
  assign pp_ll = lo_src1 * lo_src2;
  assign pp_lh = lo_src1 * hi_src2;
  assign pp_hl = hi_src1 * lo_src2;
  assign pp_hh = hi_src1 * hi_src2;

  // a flush in the issue cycle kills the op
  assign accept = i_valid & ~i_flush;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_stg.valid <= 1'b0;
    end else begin
      o_stg.valid <= accept;  // stage drains every cycle
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_stg.tag   <= '0;
      o_stg.ctrl  <= '0;
      o_stg.pp_ll <= '0;
      o_stg.pp_lh <= '0;
      o_stg.pp_hl <= '0;
      o_stg.pp_hh <= '0;
    end else if (accept) begin
      o_stg.tag   <= i_tag;
      o_stg.ctrl  <= i_ctrl;
      o_stg.pp_ll <= pp_ll;
      o_stg.pp_lh <= pp_lh;
      o_stg.pp_hl <= pp_hl;
      o_stg.pp_hh <= pp_hh;
    end
  end

endmodule

`default_nettype wire

//--- source/mul_pkg.sv
`default_nettype none

package mul_pkg;

  // operand and result width
  localparam int XLEN   = 64;

  // one operand half plus a sign bit
  localparam int HALF_W = 33;

  // product of two halves
  localparam int PP_W   = 2 * HALF_W;

  localparam int TAG_W  = 5;

  // aligned sum of all four partial products
  localparam int SUM_W  = 2 * PP_W - 2;

  typedef enum logic [2:0] {
    MUL_OP_MUL    = 3'd0,  // low 64 bits
    MUL_OP_MULH   = 3'd1,  // signed x signed, high
    MUL_OP_MULHSU = 3'd2,  // signed x unsigned, high
    MUL_OP_MULHU  = 3'd3,  // unsigned x unsigned, high
    MUL_OP_MULW   = 3'd4   // 32-bit word result
  } mul_op_e;

  // decoded control that rides along with the partial products
  typedef struct packed {
    logic src1_signed;
    logic src2_signed;
    logic sel_hi;      // take the upper half of the product
    logic word;        // sign-extend bit 31
  } mul_ctrl_t;

endpackage

`default_nettype wire

//--- source/mul_stage_if.sv
`default_nettype none

// registered products and control between the two multiplier stages
interface mul_stage_if import mul_pkg::*; ();

  logic                  valid;
  logic [TAG_W-1:0]      tag;
  mul_ctrl_t             ctrl;

  logic [PP_W-1:0]       pp_ll;  // lo1 x lo2
  logic [PP_W-1:0]       pp_lh;  // lo1 x hi2
  logic [PP_W-1:0]       pp_hl;  // hi1 x lo2
  logic [PP_W-1:0]       pp_hh;  // hi1 x hi2

  modport producer (
    output valid, tag, ctrl,
    output pp_ll, pp_lh, pp_hl, pp_hh
  );

  modport consumer (
    input valid, tag, ctrl,
    input pp_ll, pp_lh, pp_hl, pp_hh
  );

endinterface

`default_nettype wire

//--- source/mul_sum_stage.sv
`default_nettype none

module mul_sum_stage import mul_pkg::*; (
  mul_stage_if.consumer     i_stg,

  output logic              o_out_valid,
  output logic [TAG_W-1:0]  o_out_tag,
  output logic [XLEN-1:0]   o_result
);

  localparam int LO_W = XLEN / 2;

  logic [SUM_W-1:0] ll_ext;
  logic [SUM_W-1:0] lh_ext;
  logic [SUM_W-1:0] hl_ext;
  logic [SUM_W-1:0] hh_ext;
  logic [SUM_W-1:0] sum;

  logic [XLEN-1:0]  res_hi;
  logic [XLEN-1:0]  res_lo;
  logic [XLEN-1:0]  res_word;

  // ll has a zero top bit in both halves
  assign ll_ext = {{(SUM_W-PP_W){1'b0}}, i_stg.pp_ll};

  // cross terms sit at bit 32
  assign lh_ext = {{(SUM_W-PP_W-LO_W){i_stg.pp_lh[PP_W-1]}},
                   i_stg.pp_lh, {LO_W{1'b0}}};
  assign hl_ext = {{(SUM_W-PP_W-LO_W){i_stg.pp_hl[PP_W-1]}},
                   i_stg.pp_hl, {LO_W{1'b0}}};

  assign hh_ext = {i_stg.pp_hh, {XLEN{1'b0}}};

  // bits above 127 wrap away
  assign sum = ll_ext + lh_ext + hl_ext + hh_ext;

  assign res_hi   = sum[2*XLEN-1:XLEN];
  assign res_lo   = sum[XLEN-1:0];
  assign res_word = {{LO_W{sum[LO_W-1]}}, sum[LO_W-1:0]};

  always_comb begin
    if (i_stg.ctrl.sel_hi) begin
      o_result = res_hi;
    end else if (i_stg.ctrl.word) begin
      o_result = res_word;
    end else begin
      o_result = res_lo;
    end
  end

  assign o_out_valid = i_stg.valid;
  assign o_out_tag   = i_stg.tag;  // tag returns with its result

endmodule

`default_nettype wire

//--- source/mul_unit_top.sv
`default_nettype none

module mul_unit_top import mul_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,

  // issue side
  input  logic              i_valid,
  input  logic              i_flush,
  input  mul_op_e           i_op,
  input  logic [TAG_W-1:0]  i_tag,
  input  logic [XLEN-1:0]   i_multiplicand,
  input  logic [XLEN-1:0]   i_multiplier,

  // result side, one cycle after issue
  output logic              o_out_valid,
  output logic [TAG_W-1:0]  o_out_tag,
  output logic [XLEN-1:0]   o_result
);

  mul_ctrl_t issue_ctrl;

  mul_stage_if stg_if ();

  mul_op_decode u_decode (
    .i_op   (i_op),
    .o_ctrl (issue_ctrl)
  );

  // partial products, registered
  mul_partial_stage u_partial (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .i_flush        (i_flush),
    .i_tag          (i_tag),
    .i_ctrl         (issue_ctrl),
    .i_multiplicand (i_multiplicand),
    .i_multiplier   (i_multiplier),
    .o_stg          (stg_if.producer)
  );

  // final add and result select
  mul_sum_stage u_sum (
    .i_stg       (stg_if.consumer),
    .o_out_valid (o_out_valid),
    .o_out_tag   (o_out_tag),
    .o_result    (o_result)
  );

endmodule

`default_nettype wire
